// ==== gobou_mac_engine.sv ====
`default_nettype none

module gobou_mac_engine #(
  parameter int WORD_ADDR_WIDTH = 10
) (
  input  logic                       clk,
  input  logic                       xrst,
  input  logic                       mac_start,
  input  logic [WORD_ADDR_WIDTH-1:0] mac_base,
  input  logic [7:0]                 mac_count,
  output logic                       mac_busy,
  output logic                       mac_done,
  output logic [31:0]                mac_result,
  ninjin_mem_if.requester            mem
);

  logic [WORD_ADDR_WIDTH-1:0] issue_addr;
  logic [7:0]                 issue_left;
  logic [7:0]                 ret_left;
  logic                       issue_fire;
  logic                       finish;
  logic                       prod_valid;
  logic signed [31:0]         prod_q;

  // ========================================================================
  // read issue
  // ========================================================================

  // reads go out back to back whenever granted
  assign mem.req    = mac_busy && (issue_left != '0);
  assign mem.we     = 1'b0;
  assign mem.addr   = issue_addr;
  assign mem.be     = '1;
  assign mem.wdata  = '0;
  assign issue_fire = mem.req && mem.gnt;

  // all words back and the last product added
  assign finish = mac_busy && (issue_left == '0) && (ret_left == '0) && !prod_valid;

  always_ff @(posedge clk) begin
    if (!xrst) begin
      mac_busy   <= 1'b0;
      mac_done   <= 1'b0;
      issue_left <= '0;
      ret_left   <= '0;
    end else begin
      mac_done <= finish;
      if (mac_start && !mac_busy) begin
        mac_busy   <= 1'b1;
        issue_left <= mac_count;
        ret_left   <= mac_count;
      end else begin
        if (finish)
          mac_busy <= 1'b0;
        if (issue_fire)
          issue_left <= issue_left - 1'b1;
        if (mem.rvalid)
          ret_left <= ret_left - 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (mac_start && !mac_busy)
      issue_addr <= mac_base;
    else if (issue_fire)
      issue_addr <= issue_addr + 1'b1;
  end

  // ========================================================================
  // multiply then accumulate
  // ========================================================================

  always_ff @(posedge clk) begin
    if (!xrst) begin
      prod_valid <= 1'b0;
      mac_result <= '0;
    end else begin
      prod_valid <= mem.rvalid;
      if (mac_start && !mac_busy)
        mac_result <= '0;
      else if (prod_valid)
        mac_result <= mac_result + prod_q;
    end
  end

  // signed 16 x 16 into a full 32-bit product
  always_ff @(posedge clk) begin
    if (mem.rvalid)
      prod_q <= mem.rdata.pair.weight * mem.rdata.pair.act;
  end

endmodule

`default_nettype wire

// ==== ninjin_axi_pkg.sv ====
`default_nettype none

// AXI4 encodings used by the burst slave
package ninjin_axi_pkg;

  // burst types
  localparam logic [1:0] burst_fixed = 2'b00;
  localparam logic [1:0] burst_incr  = 2'b01;
  localparam logic [1:0] burst_wrap  = 2'b10;

  // response codes, only OKAY is ever returned
  localparam logic [1:0] resp_okay   = 2'b00;

  // every beat is a full word
  localparam int beat_bytes = 4;

endpackage

`default_nettype wire

// ==== ninjin_gobou_top.f ====
ninjin_axi_pkg.sv
ninjin_mem_pkg.sv
ninjin_mem_if.sv
ninjin_s_axi_gobou.sv
gobou_mac_engine.sv
ninjin_mem_arbiter.sv
ninjin_param_ram.sv
ninjin_gobou_top.sv
tb_ninjin_gobou_assertions.sv
tb_ninjin_gobou.sv

// ==== ninjin_gobou_top.sv ====
`default_nettype none

module ninjin_gobou_top #(
  parameter int ADDR_WIDTH = 12,
  parameter int ID_WIDTH   = 12
) (
  input  logic                                    clk,
  input  logic                                    xrst,
  input  logic [ID_WIDTH-1:0]                     awid,
  input  logic [ADDR_WIDTH-1:0]                   awaddr,
  input  logic [7:0]                              awlen,
  input  logic [1:0]                              awburst,
  input  logic                                    awvalid,
  output logic                                    awready,
  input  logic [ninjin_mem_pkg::data_width-1:0]   wdata,
  input  logic [ninjin_mem_pkg::data_width/8-1:0] wstrb,
  input  logic                                    wlast,
  input  logic                                    wvalid,
  output logic                                    wready,
  output logic                                    bvalid,
  output logic [ID_WIDTH-1:0]                     bid,
  output logic [1:0]                              bresp,
  input  logic                                    bready,
  input  logic [ID_WIDTH-1:0]                     arid,
  input  logic [ADDR_WIDTH-1:0]                   araddr,
  input  logic [7:0]                              arlen,
  input  logic [1:0]                              arburst,
  input  logic                                    arvalid,
  output logic                                    arready,
  output logic                                    rvalid,
  output logic [ID_WIDTH-1:0]                     rid,
  output logic [ninjin_mem_pkg::data_width-1:0]   rdata,
  output logic [1:0]                              rresp,
  output logic                                    rlast,
  input  logic                                    rready,
  input  logic                                    mac_start,
  input  logic [ADDR_WIDTH-3:0]                   mac_base,
  input  logic [7:0]                              mac_count,
  output logic                                    mac_busy,
  output logic                                    mac_done,
  output logic [31:0]                             mac_result
);

  // word address drops the byte offset of a 32-bit beat
  localparam int WORD_ADDR_WIDTH = ADDR_WIDTH - 2;

  logic                                  ram_en;
  logic                                  ram_we;
  logic [WORD_ADDR_WIDTH-1:0]            ram_addr;
  logic [ninjin_mem_pkg::data_width/8-1:0] ram_be;
  logic [ninjin_mem_pkg::data_width-1:0] ram_wdata;
  logic [ninjin_mem_pkg::data_width-1:0] ram_rdata;

  ninjin_mem_if #(.WORD_ADDR_WIDTH(WORD_ADDR_WIDTH)) axi_mem ();
  ninjin_mem_if #(.WORD_ADDR_WIDTH(WORD_ADDR_WIDTH)) mac_mem ();

  ninjin_s_axi_gobou #(
    .ADDR_WIDTH(ADDR_WIDTH),
    .ID_WIDTH  (ID_WIDTH)
  ) ninjin_s_axi_gobou_i (
    .clk, .xrst,
    .awid, .awaddr, .awlen, .awburst, .awvalid, .awready,
    .wdata, .wstrb, .wlast, .wvalid, .wready,
    .bvalid, .bid, .bresp, .bready,
    .arid, .araddr, .arlen, .arburst, .arvalid, .arready,
    .rvalid, .rid, .rdata, .rresp, .rlast, .rready,
    .mem(axi_mem.requester)
  );

  gobou_mac_engine #(
    .WORD_ADDR_WIDTH(WORD_ADDR_WIDTH)
  ) gobou_mac_engine_i (
    .clk, .xrst,
    .mac_start, .mac_base, .mac_count,
    .mac_busy, .mac_done, .mac_result,
    .mem(mac_mem.requester)
  );

  ninjin_mem_arbiter #(
    .WORD_ADDR_WIDTH(WORD_ADDR_WIDTH)
  ) ninjin_mem_arbiter_i (
    .clk, .xrst,
    .axi_mem(axi_mem.arbiter),
    .mac_mem(mac_mem.arbiter),
    .ram_en, .ram_we, .ram_addr, .ram_be, .ram_wdata, .ram_rdata
  );

  ninjin_param_ram #(
    .WORD_ADDR_WIDTH(WORD_ADDR_WIDTH)
  ) ninjin_param_ram_i (
    .clk,
    .en   (ram_en),
    .we   (ram_we),
    .addr (ram_addr),
    .be   (ram_be),
    .wdata(ram_wdata),
    .rdata(ram_rdata)
  );

endmodule

`default_nettype wire

// ==== ninjin_mem_arbiter.sv ====
`default_nettype none

module ninjin_mem_arbiter #(
  parameter int WORD_ADDR_WIDTH = 10
) (
  input  logic                                    clk,
  input  logic                                    xrst,
  ninjin_mem_if.arbiter                           axi_mem,
  ninjin_mem_if.arbiter                           mac_mem,
  output logic                                    ram_en,
  output logic                                    ram_we,
  output logic [WORD_ADDR_WIDTH-1:0]              ram_addr,
  output logic [ninjin_mem_pkg::data_width/8-1:0] ram_be,
  output logic [ninjin_mem_pkg::data_width-1:0]   ram_wdata,
  input  logic [ninjin_mem_pkg::data_width-1:0]   ram_rdata
);

  logic                     rd_pending;
  ninjin_mem_pkg::mem_sel_t rd_sel;

  // fixed priority, AXI first
  assign axi_mem.gnt = axi_mem.req;
  assign mac_mem.gnt = mac_mem.req && !axi_mem.req;

  assign ram_en    = axi_mem.req || mac_mem.req;
  assign ram_we    = axi_mem.req ? axi_mem.we        : mac_mem.we;
  assign ram_addr  = axi_mem.req ? axi_mem.addr      : mac_mem.addr;
  assign ram_be    = axi_mem.req ? axi_mem.be        : mac_mem.be;
  assign ram_wdata = axi_mem.req ? axi_mem.wdata.raw : mac_mem.wdata.raw;

  // remember who owns the word coming back next cycle
  always_ff @(posedge clk) begin
    if (!xrst) begin
      rd_pending <= 1'b0;
      rd_sel     <= ninjin_mem_pkg::sel_axi;
    end else begin
      rd_pending <= ram_en && !ram_we;
      if (ram_en && !ram_we)
        rd_sel <= axi_mem.req ? ninjin_mem_pkg::sel_axi : ninjin_mem_pkg::sel_mac;
    end
  end

  assign axi_mem.rdata  = ninjin_mem_pkg::mem_word_t'(ram_rdata);
  assign mac_mem.rdata  = ninjin_mem_pkg::mem_word_t'(ram_rdata);
  assign axi_mem.rvalid = rd_pending && (rd_sel == ninjin_mem_pkg::sel_axi);
  assign mac_mem.rvalid = rd_pending && (rd_sel == ninjin_mem_pkg::sel_mac);

endmodule

`default_nettype wire

// ==== ninjin_mem_if.sv ====
`default_nettype none

// one requester path into the shared RAM
interface ninjin_mem_if #(
  parameter int WORD_ADDR_WIDTH = 10
);

  logic                                  req;
  logic                                  we;
  logic [WORD_ADDR_WIDTH-1:0]            addr;
  logic [ninjin_mem_pkg::data_width/8-1:0] be;
  ninjin_mem_pkg::mem_word_t             wdata;
  logic                                  gnt;
  ninjin_mem_pkg::mem_word_t             rdata;
  logic                                  rvalid;

  modport requester (output req, we, addr, be, wdata, input gnt, rdata, rvalid);
  modport arbiter   (input req, we, addr, be, wdata, output gnt, rdata, rvalid);

endinterface

`default_nettype wire

// ==== ninjin_mem_pkg.sv ====
`default_nettype none

// shared parameter RAM word and port ownership
package ninjin_mem_pkg;

  localparam int data_width = 32;

  // engine view of a word: weight high, activation low
  typedef struct packed {
    logic signed [data_width/2-1:0] weight;
    logic signed [data_width/2-1:0] act;
  } mem_pair_t;

  typedef union packed {
    logic [data_width-1:0] raw;
    mem_pair_t             pair;
  } mem_word_t;

  // owner of the read in flight
  typedef enum logic {
    sel_axi = 1'b0,
    sel_mac = 1'b1
  } mem_sel_t;

endpackage

`default_nettype wire

// ==== ninjin_param_ram.sv ====
`default_nettype none

module ninjin_param_ram #(
  parameter int WORD_ADDR_WIDTH = 10
) (
  input  logic                                    clk,
  input  logic                                    en,
  input  logic                                    we,
  input  logic [WORD_ADDR_WIDTH-1:0]              addr,
  input  logic [ninjin_mem_pkg::data_width/8-1:0] be,
  input  logic [ninjin_mem_pkg::data_width-1:0]   wdata,
  output logic [ninjin_mem_pkg::data_width-1:0]   rdata
);

  logic [ninjin_mem_pkg::data_width-1:0] mem [2**WORD_ADDR_WIDTH];

  // byte-wise write, registered read
  always_ff @(posedge clk) begin
    if (en) begin
      if (we) begin
        for (int i = 0; i < ninjin_mem_pkg::data_width / 8; i++) begin
          if (be[i])
            mem[addr][8*i +: 8] <= wdata[8*i +: 8];
        end
      end else begin
        rdata <= mem[addr];
      end
    end
  end

endmodule

`default_nettype wire

// ==== ninjin_s_axi_gobou.sv ====
`default_nettype none

module ninjin_s_axi_gobou #(
  parameter int ADDR_WIDTH = 12,
  parameter int ID_WIDTH   = 12
) (
  input  logic                                    clk,
  input  logic                                    xrst,
  input  logic [ID_WIDTH-1:0]                     awid,
  input  logic [ADDR_WIDTH-1:0]                   awaddr,
  input  logic [7:0]                              awlen,
  input  logic [1:0]                              awburst,
  input  logic                                    awvalid,
  output logic                                    awready,
  input  logic [ninjin_mem_pkg::data_width-1:0]   wdata,
  input  logic [ninjin_mem_pkg::data_width/8-1:0] wstrb,
  input  logic                                    wlast,
  input  logic                                    wvalid,
  output logic                                    wready,
  output logic                                    bvalid,
  output logic [ID_WIDTH-1:0]                     bid,
  output logic [1:0]                              bresp,
  input  logic                                    bready,
  input  logic [ID_WIDTH-1:0]                     arid,
  input  logic [ADDR_WIDTH-1:0]                   araddr,
  input  logic [7:0]                              arlen,
  input  logic [1:0]                              arburst,
  input  logic                                    arvalid,
  output logic                                    arready,
  output logic                                    rvalid,
  output logic [ID_WIDTH-1:0]                     rid,
  output logic [ninjin_mem_pkg::data_width-1:0]   rdata,
  output logic [1:0]                              rresp,
  output logic                                    rlast,
  input  logic                                    rready,
  ninjin_mem_if.requester                         mem
);

  localparam int beat_lsb = $clog2(ninjin_axi_pkg::beat_bytes);

  logic                                  wr_active;
  logic                                  rd_active;
  logic                                  rd_issue;
  logic                                  idle;
  logic                                  aw_take;
  logic                                  ar_take;
  logic                                  w_beat;
  logic                                  r_beat;
  logic                                  mem_fire;
  logic [ID_WIDTH-1:0]                   id_q;
  logic [ADDR_WIDTH-1:0]                 addr_q;
  logic [7:0]                            len_q;
  logic [7:0]                            cnt_q;
  logic [1:0]                            burst_q;
  logic [ninjin_mem_pkg::data_width-1:0] rdata_q;

  // address of the beat after this one
  function automatic logic [ADDR_WIDTH-1:0] next_addr(
    input logic [ADDR_WIDTH-1:0] addr,
    input logic [7:0]            len,
    input logic [1:0]            burst
  );
    logic [ADDR_WIDTH-1:0] step_addr;
    logic [ADDR_WIDTH-1:0] wrap_mask;
    step_addr = addr + ADDR_WIDTH'(ninjin_axi_pkg::beat_bytes);
    // window of (len+1) beats, aligned to its own size
    wrap_mask = ((ADDR_WIDTH'(len) + 1'b1) << beat_lsb) - 1'b1;
    case (burst)
      ninjin_axi_pkg::burst_fixed: next_addr = addr;
      ninjin_axi_pkg::burst_incr:  next_addr = step_addr;
      ninjin_axi_pkg::burst_wrap:  next_addr = (addr & ~wrap_mask) | (step_addr & wrap_mask);
      // reserved code 3 acts as INCR
      default:                     next_addr = step_addr;
    endcase
  endfunction

  // ========================================================================
  // address acceptance
  // ========================================================================

  // one burst at a time, write wins a tie
  assign idle    = !wr_active && !rd_active && !bvalid;
  assign aw_take = idle && awvalid;
  assign ar_take = idle && arvalid && !awvalid;

  assign w_beat = wready && wvalid;
  assign r_beat = rvalid && rready;

  always_ff @(posedge clk) begin
    if (aw_take) begin
      id_q    <= awid;
      addr_q  <= {awaddr[ADDR_WIDTH-1:beat_lsb], {beat_lsb{1'b0}}};
      len_q   <= awlen;
      burst_q <= awburst;
    end else if (ar_take) begin
      id_q    <= arid;
      addr_q  <= {araddr[ADDR_WIDTH-1:beat_lsb], {beat_lsb{1'b0}}};
      len_q   <= arlen;
      burst_q <= arburst;
      cnt_q   <= '0;
    end else if (w_beat) begin
      addr_q <= next_addr(addr_q, len_q, burst_q);
    end else if (r_beat && !rlast) begin
      addr_q <= next_addr(addr_q, len_q, burst_q);
      cnt_q  <= cnt_q + 1'b1;
    end
  end

  // ========================================================================
  // write channels
  // ========================================================================

  always_ff @(posedge clk) begin
    if (!xrst) begin
      awready   <= 1'b0;
      wr_active <= 1'b0;
      wready    <= 1'b0;
      bvalid    <= 1'b0;
    end else begin
      awready <= aw_take;
      if (aw_take)
        wr_active <= 1'b1;
      else if (w_beat && wlast)
        wr_active <= 1'b0;
      if (w_beat && wlast)
        wready <= 1'b0;
      else if (wr_active && wvalid)
        wready <= 1'b1;
      if (w_beat && wlast)
        bvalid <= 1'b1;
      else if (bready)
        bvalid <= 1'b0;
    end
  end

  assign bid   = id_q;
  assign bresp = ninjin_axi_pkg::resp_okay;

  // ========================================================================
  // read channels
  // ========================================================================

  always_ff @(posedge clk) begin
    if (!xrst) begin
      arready   <= 1'b0;
      rd_active <= 1'b0;
      rd_issue  <= 1'b0;
      rvalid    <= 1'b0;
      rlast     <= 1'b0;
    end else begin
      arready <= ar_take;
      if (ar_take)
        rd_active <= 1'b1;
      else if (r_beat && rlast)
        rd_active <= 1'b0;
      // next fetch only after the handshake
      if (ar_take || (r_beat && !rlast))
        rd_issue <= 1'b1;
      else if (mem_fire)
        rd_issue <= 1'b0;
      if (rd_issue && mem_fire) begin
        rvalid <= 1'b1;
        rlast  <= (cnt_q == len_q);
      end else if (r_beat) begin
        rvalid <= 1'b0;
        rlast  <= 1'b0;
      end
    end
  end

  // hold the RAM word until rready
  always_ff @(posedge clk) begin
    if (mem.rvalid)
      rdata_q <= mem.rdata.raw;
  end

  assign rdata = mem.rvalid ? mem.rdata.raw : rdata_q;
  assign rid   = id_q;
  assign rresp = ninjin_axi_pkg::resp_okay;

  // ========================================================================
  // RAM requests
  // ========================================================================

  assign mem.req   = w_beat || rd_issue;
  assign mem_fire  = mem.req && mem.gnt;
  assign mem.we    = wr_active;
  assign mem.addr  = addr_q[ADDR_WIDTH-1:beat_lsb];
  assign mem.be    = wstrb;
  assign mem.wdata = ninjin_mem_pkg::mem_word_t'(wdata);

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the ninjin/gobou testbench with Verilator.
set -u

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert \
  -f ninjin_gobou_top.f \
  --top-module tb_ninjin_gobou \
  -Mdir obj_dir -o sim_tb
status=$?
if [ "$status" -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit 1
fi

./obj_dir/sim_tb > "$log" 2>&1
status=$?
cat "$log"

if grep -q "Simulation failed" "$log"; then
  echo "testbench reported failure"
  exit 1
fi

if [ "$status" -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

exit 0

// ==== tb_ninjin_gobou.sv ====
`default_nettype none

module tb_ninjin_gobou;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int addr_width   = 12;
  localparam int id_width     = 12;
  localparam int word_count   = 2 ** (addr_width - 2);
  localparam int reset_cycles = 10;

  typedef enum int {op_write, op_read, op_mac, op_mac_axi} op_t;

  typedef struct {
    string                 name;
    op_t                   op;
    logic [addr_width-1:0] addr;
    logic [7:0]            len;
    logic [1:0]            burst;
    logic [3:0]            strb;
    logic [addr_width-3:0] mac_base;
    logic [7:0]            mac_count;
  } test_row_t;

  logic                  clk;
  logic                  xrst;
  logic [id_width-1:0]   awid;
  logic [addr_width-1:0] awaddr;
  logic [7:0]            awlen;
  logic [1:0]            awburst;
  logic                  awvalid;
  logic                  awready;
  logic [31:0]           wdata;
  logic [3:0]            wstrb;
  logic                  wlast;
  logic                  wvalid;
  logic                  wready;
  logic                  bvalid;
  logic [id_width-1:0]   bid;
  logic [1:0]            bresp;
  logic                  bready;
  logic [id_width-1:0]   arid;
  logic [addr_width-1:0] araddr;
  logic [7:0]            arlen;
  logic [1:0]            arburst;
  logic                  arvalid;
  logic                  arready;
  logic                  rvalid;
  logic [id_width-1:0]   rid;
  logic [31:0]           rdata;
  logic [1:0]            rresp;
  logic                  rlast;
  logic                  rready;
  logic                  mac_start;
  logic [addr_width-3:0] mac_base;
  logic [7:0]            mac_count;
  logic                  mac_busy;
  logic                  mac_done;
  logic [31:0]           mac_result;

  test_row_t   rows[$];
  logic [31:0] ref_mem [word_count];
  string       test_name;
  int          cycle_count = 0;
  int          cycle_limit = 0;

  ninjin_gobou_top #(
    .ADDR_WIDTH(addr_width),
    .ID_WIDTH  (id_width)
  ) ninjin_gobou_top_i (.*);

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // watchdog sized from the stimulus table
  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count > cycle_limit) begin
      $display("run timed out after %0d cycles", cycle_count);
      $display("Simulation failed");
      $fatal(1, "timeout");
    end
  end

  // ==========================================================================
  // reference models
  // ==========================================================================

  task automatic ref_write(input int word, input logic [31:0] data, input logic [3:0] strb);
    for (int i = 0; i < 4; i++) begin
      if (strb[i])
        ref_mem[word][8*i +: 8] = data[8*i +: 8];
    end
  endtask

  function automatic logic [addr_width-1:0] next_beat_addr(
    input logic [addr_width-1:0] addr,
    input logic [7:0]            len,
    input logic [1:0]            burst
  );
    int window;
    int base;
    int offset;
    window = (int'(len) + 1) * ninjin_axi_pkg::beat_bytes;
    base   = (int'(addr) / window) * window;
    offset = (int'(addr) - base + ninjin_axi_pkg::beat_bytes) % window;
    if (burst == ninjin_axi_pkg::burst_fixed)
      return addr;
    else if (burst == ninjin_axi_pkg::burst_wrap)
      return addr_width'(base + offset);
    else
      return addr + addr_width'(ninjin_axi_pkg::beat_bytes);
  endfunction

  // signed weight x activation summed with 32-bit wrap
  function automatic logic [31:0] mac_model(input int base, input int count);
    logic signed [31:0] weight;
    logic signed [31:0] act;
    logic signed [31:0] sum;
    sum = 0;
    for (int i = 0; i < count; i++) begin
      weight = $signed(ref_mem[base + i][31:16]);
      act    = $signed(ref_mem[base + i][15:0]);
      sum    = sum + weight * act;
    end
    return sum;
  endfunction

  // ==========================================================================
  // drivers
  // ==========================================================================

  task automatic advance_cycle();
    @(posedge clk);
    #5;
  endtask

  task automatic check_equal(input string what, input logic [31:0] expected,
                             input logic [31:0] actual);
    assert (actual === expected) else begin
      $display("** Error: %s %s expected %h actual %h", test_name, what, expected, actual);
      $display("Simulation failed");
      $fatal(1, "value mismatch");
    end
  endtask

  task automatic axi_write_burst(input test_row_t row);
    logic [addr_width-1:0] beat_addr;
    logic [id_width-1:0]   id;
    logic [31:0]           data;
    int                    stall;
    id      = id_width'($urandom);
    awid    = id;
    awaddr  = row.addr;
    awlen   = row.len;
    awburst = row.burst;
    awvalid = 1'b1;
    do @(negedge clk); while (!awready);
    advance_cycle();
    awvalid   = 1'b0;
    beat_addr = row.addr;
    for (int beat = 0; beat <= int'(row.len); beat++) begin
      data   = $urandom;
      wdata  = data;
      wstrb  = row.strb;
      wlast  = (beat == int'(row.len));
      wvalid = 1'b1;
      do @(negedge clk); while (!wready);
      advance_cycle();
      ref_write(int'(beat_addr[addr_width-1:2]), data, row.strb);
      beat_addr = next_beat_addr(beat_addr, row.len, row.burst);
    end
    wvalid = 1'b0;
    wlast  = 1'b0;
    do @(negedge clk); while (!bvalid);
    check_equal("bid", 32'(id), 32'(bid));
    check_equal("bresp", 32'(ninjin_axi_pkg::resp_okay), 32'(bresp));
    // master holds off the write response
    stall = 1 + ($urandom % 3);
    repeat (stall) advance_cycle();
    bready = 1'b1;
    advance_cycle();
    bready = 1'b0;
  endtask

  task automatic axi_read_burst(input test_row_t row);
    logic [addr_width-1:0] beat_addr;
    logic [id_width-1:0]   id;
    logic                  accepted;
    id      = id_width'($urandom);
    arid    = id;
    araddr  = row.addr;
    arlen   = row.len;
    arburst = row.burst;
    arvalid = 1'b1;
    do @(negedge clk); while (!arready);
    advance_cycle();
    arvalid   = 1'b0;
    beat_addr = row.addr;
    for (int beat = 0; beat <= int'(row.len); beat++) begin
      accepted = 1'b0;
      while (!accepted) begin
        // random back-pressure on R
        rready = ($urandom % 4) != 0;
        @(negedge clk);
        if (rvalid && rready) begin
          check_equal($sformatf("rdata beat %0d", beat),
                      ref_mem[int'(beat_addr[addr_width-1:2])], rdata);
          check_equal("rlast", 32'(beat == int'(row.len)), 32'(rlast));
          check_equal("rid", 32'(id), 32'(rid));
          check_equal("rresp", 32'(ninjin_axi_pkg::resp_okay), 32'(rresp));
          accepted = 1'b1;
        end
        advance_cycle();
      end
      beat_addr = next_beat_addr(beat_addr, row.len, row.burst);
    end
    rready = 1'b0;
  endtask

  task automatic mac_run(input test_row_t row);
    logic [31:0] expected;
    expected  = mac_model(int'(row.mac_base), int'(row.mac_count));
    mac_base  = row.mac_base;
    mac_count = row.mac_count;
    mac_start = 1'b1;
    advance_cycle();
    mac_start = 1'b0;
    @(negedge clk);
    check_equal("mac_busy", 32'd1, 32'(mac_busy || mac_done));
    while (!mac_done)
      @(negedge clk);
    check_equal("mac_result", expected, mac_result);
    advance_cycle();
  endtask

  task automatic add_row(input string name, input op_t op, input logic [addr_width-1:0] addr,
                         input logic [7:0] len, input logic [1:0] burst, input logic [3:0] strb,
                         input logic [addr_width-3:0] base, input logic [7:0] count);
    test_row_t row;
    row.name      = name;
    row.op        = op;
    row.addr      = addr;
    row.len       = len;
    row.burst     = burst;
    row.strb      = strb;
    row.mac_base  = base;
    row.mac_count = count;
    rows.push_back(row);
  endtask

  // ==========================================================================
  // stimulus table and main sequence
  // ==========================================================================

  initial begin
    void'($urandom(32'h6acc));
    xrst      = 1'b0;
    awid      = '0;
    awaddr    = '0;
    awlen     = '0;
    awburst   = '0;
    awvalid   = 1'b0;
    wdata     = '0;
    wstrb     = '0;
    wlast     = 1'b0;
    wvalid    = 1'b0;
    bready    = 1'b0;
    arid      = '0;
    araddr    = '0;
    arlen     = '0;
    arburst   = '0;
    arvalid   = 1'b0;
    rready    = 1'b0;
    mac_start = 1'b0;
    mac_base  = '0;
    mac_count = '0;

    add_row("incr_write8", op_write, 12'h000, 8'd7, ninjin_axi_pkg::burst_incr, 4'hf, 0, 0);
    add_row("incr_read8", op_read, 12'h000, 8'd7, ninjin_axi_pkg::burst_incr, 4'hf, 0, 0);
    add_row("wrap_write4", op_write, 12'h108, 8'd3, ninjin_axi_pkg::burst_wrap, 4'hf, 0, 0);
    add_row("wrap_readback", op_read, 12'h100, 8'd3, ninjin_axi_pkg::burst_incr, 4'hf, 0, 0);
    add_row("fixed_write4", op_write, 12'h200, 8'd3, ninjin_axi_pkg::burst_fixed, 4'hf, 0, 0);
    add_row("fixed_read4", op_read, 12'h200, 8'd3, ninjin_axi_pkg::burst_fixed, 4'hf, 0, 0);
    add_row("strobe_write", op_write, 12'h000, 8'd3, ninjin_axi_pkg::burst_incr, 4'h6, 0, 0);
    add_row("strobe_read", op_read, 12'h000, 8'd7, ninjin_axi_pkg::burst_incr, 4'hf, 0, 0);
    add_row("mac_fill", op_write, 12'h300, 8'd15, ninjin_axi_pkg::burst_incr, 4'hf, 0, 0);
    add_row("mac_run16", op_mac, 12'h000, 8'd0, ninjin_axi_pkg::burst_incr, 4'hf, 10'hc0, 16);
    add_row("mac_count0", op_mac, 12'h000, 8'd0, ninjin_axi_pkg::burst_incr, 4'hf, 10'h00, 0);
    add_row("mac_with_write", op_mac_axi, 12'h040, 8'd7, ninjin_axi_pkg::burst_incr, 4'hf,
            10'hc0, 16);
    add_row("read_after_mac", op_read, 12'h040, 8'd7, ninjin_axi_pkg::burst_incr, 4'hf, 0, 0);
    add_row("mac_run8", op_mac, 12'h000, 8'd0, ninjin_axi_pkg::burst_incr, 4'hf, 10'h00, 8);

    cycle_limit = reset_cycles;
    foreach (rows[i])
      cycle_limit += (int'(rows[i].len) + 1) * 6 + 40;

    repeat (reset_cycles) @(posedge clk);
    #5;
    xrst = 1'b1;
    advance_cycle();

    foreach (rows[i]) begin
      test_name = rows[i].name;
      case (rows[i].op)
        op_write: axi_write_burst(rows[i]);
        op_read:  axi_read_burst(rows[i]);
        op_mac:   mac_run(rows[i]);
        default: begin
          // engine and host contend for the RAM
          fork
            axi_write_burst(rows[i]);
            mac_run(rows[i]);
          join
        end
      endcase
    end

    $display("Simulation completed successfully");
    $finish;
  end

endmodule

`default_nettype wire

// ==== tb_ninjin_gobou_assertions.sv ====
`default_nettype none

module tb_ninjin_gobou_assertions (
  input logic                                  clk,
  input logic                                  xrst,
  input logic                                  awready,
  input logic                                  arready,
  input logic                                  bvalid,
  input logic                                  bready,
  input logic                                  rvalid,
  input logic                                  rready,
  input logic [ninjin_mem_pkg::data_width-1:0] rdata,
  input logic                                  mac_busy,
  input logic                                  mac_done
);
  timeunit 1ns;
  timeprecision 1ps;

  // write response waits for the master
  assert property (@(posedge clk) disable iff (!xrst)
    bvalid && !bready |=> bvalid)
    else $error("bvalid dropped before bready");

  // read beat held steady under back-pressure
  assert property (@(posedge clk) disable iff (!xrst)
    rvalid && !rready |=> rvalid && $stable(rdata))
    else $error("rvalid or rdata changed before rready");

  // only one address channel accepted at a time
  assert property (@(posedge clk) disable iff (!xrst)
    !(awready && arready))
    else $error("awready and arready high together");

  // done pulse, busy falls with it
  assert property (@(posedge clk) disable iff (!xrst)
    mac_done |=> !mac_done)
    else $error("mac_done longer than one cycle");

  assert property (@(posedge clk) disable iff (!xrst)
    mac_done |-> !mac_busy && $past(mac_busy))
    else $error("mac_done not aligned with mac_busy falling");

endmodule

bind ninjin_gobou_top tb_ninjin_gobou_assertions tb_ninjin_gobou_assertions_i (
  .clk     (clk),
  .xrst    (xrst),
  .awready (awready),
  .arready (arready),
  .bvalid  (bvalid),
  .bready  (bready),
  .rvalid  (rvalid),
  .rready  (rready),
  .rdata   (rdata),
  .mac_busy(mac_busy),
  .mac_done(mac_done)
);

`default_nettype wire
